// ==== verilog.f ====
logic/per_bus_pkg.sv
logic/axi_bus_pkg.sv
logic/per_arbiter.sv
logic/per2axi_req_channel.sv
logic/per2axi_res_channel.sv
logic/per2axi_busy_unit.sv
logic/per2axi_bridge.sv
verif/axi_mem_model.sv
verif/tb_per2axi.sv

// ==== Bender.yml ====
package:
  name: per2axi

sources:
  - files:
      - logic/per_bus_pkg.sv
      - logic/axi_bus_pkg.sv
      - logic/per_arbiter.sv
      - logic/per2axi_req_channel.sv
      - logic/per2axi_res_channel.sv
      - logic/per2axi_busy_unit.sv
      - logic/per2axi_bridge.sv
  - target: test
    files:
      - verif/axi_mem_model.sv
      - verif/tb_per2axi.sv

// ==== verif/tb_per2axi.sv ====
/*
 * Testbench for the peripheral to AXI4 bridge. Four cores issue random
 * requests from an LFSR; a reference model predicts grants, AXI beats,
 * responses and busy, and every cycle is compared against the DUT.
 */
`timescale 1ns/1ps

module tb_per2axi;

   localparam int unsigned NB          = per_bus_pkg::NB_CORES;
   localparam int unsigned N_REQ       = 400;
   localparam int unsigned CYCLE_LIMIT = N_REQ * 8;

   logic clk_i = 1'b0;
   logic rst_n_i;

   per_bus_pkg::per_req_t  [NB-1:0] per_req;
   logic                   [NB-1:0] per_gnt;
   per_bus_pkg::per_resp_t [NB-1:0] per_resp;

   logic                 aw_valid, w_valid, ar_valid, b_valid, r_valid;
   logic                 aw_ready, w_ready, ar_ready, busy;
   axi_bus_pkg::axi_ax_t aw, ar;
   axi_bus_pkg::axi_w_t  w;
   axi_bus_pkg::axi_b_t  b;
   axi_bus_pkg::axi_r_t  r;
   logic                 stall;
   logic [1:0]           lat;

   // Reference state
   logic [15:0]            lfsr = 16'd13851;
   logic [7:0]             shadow [logic [31:0]];
   int unsigned            state [NB] = '{default: 0};   // 0 idle, 1 request, 2 waiting
   per_bus_pkg::per_resp_t exp_rsp [NB];
   logic [NB-1:0]          exp_read = '0;
   logic [NB-1:0]          due = '0;
   logic [31:0]            last_rdata = 'x;
   logic                   last_opc = 1'bx;
   int unsigned            ptr = 0;
   int unsigned            outst = 0;
   int unsigned            n_issued = 0;
   int unsigned            n_done = 0;
   int unsigned            cycles = 0;

   always #10 clk_i = ~clk_i;

   per2axi_bridge UUT (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .per_req_i (per_req), .per_gnt_o (per_gnt), .per_resp_o (per_resp),
      .aw_valid_o (aw_valid), .aw_o (aw), .aw_ready_i (aw_ready),
      .w_valid_o (w_valid), .w_o (w), .w_ready_i (w_ready),
      .ar_valid_o (ar_valid), .ar_o (ar), .ar_ready_i (ar_ready),
      .b_valid_i (b_valid), .b_i (b), .r_valid_i (r_valid), .r_i (r),
      .busy_o (busy)
   );

   axi_mem_model u_mem (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .stall_i (stall), .lat_i (lat),
      .aw_valid_i (aw_valid), .aw_i (aw), .aw_ready_o (aw_ready),
      .w_valid_i (w_valid), .w_i (w), .w_ready_o (w_ready),
      .ar_valid_i (ar_valid), .ar_i (ar), .ar_ready_o (ar_ready),
      .b_valid_o (b_valid), .b_o (b), .r_valid_o (r_valid), .r_o (r)
   );

   // ****************************************
   // Helpers
   // ****************************************
   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[0];
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [7:0] shadow_byte(input logic [31:0] a);
      logic [31:0] base;
      logic [63:0] word;
      base = {a[31:3], 3'b000};
      word = {~base, base};
      return shadow.exists(a) ? shadow[a] : word[8*a[2:0] +: 8];
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check_resp(input string name, input per_bus_pkg::per_resp_t got,
                             input per_bus_pkg::per_resp_t exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_ax(input string name, input axi_bus_pkg::axi_ax_t got,
                           input axi_bus_pkg::axi_ax_t exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_w(input string name, input axi_bus_pkg::axi_w_t got,
                          input axi_bus_pkg::axi_w_t exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_gnt(input string name, input logic [NB-1:0] got,
                            input logic [NB-1:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // Expected AXI beats and core response; writes update the shadow memory
   function automatic void ref_model(input per_bus_pkg::per_req_t q, input int c,
                                     output axi_bus_pkg::axi_ax_t ax,
                                     output axi_bus_pkg::axi_w_t wb,
                                     output per_bus_pkg::per_resp_t rsp);
      logic        is_lr, is_sc, redirect;
      logic [31:0] wa;
      is_lr    = q.atop[5] && q.atop[4:0] == per_bus_pkg::AMO_LR;
      is_sc    = q.atop[5] && q.atop[4:0] == per_bus_pkg::AMO_SC;
      redirect = q.atop[5] && !is_lr && !is_sc;
      ax.addr  = redirect ? (axi_bus_pkg::ERR_REGION_BASE | {20'b0, q.add[11:0]}) : q.add;
      if (q.be == (4'b0001 << q.add[1:0])) begin
         ax.size = 3'd0;
      end else if ((q.be == 4'b0011 && q.add[1:0] == 2'd0) ||
                   (q.be == 4'b1100 && q.add[1:0] == 2'd2)) begin
         ax.size = 3'd1;
      end else begin
         ax.size = 3'd2;
      end
      ax.len   = 8'd0;
      ax.burst = axi_bus_pkg::BURST_INCR;
      ax.lock  = (is_lr && q.wen) || (is_sc && !q.wen);
      ax.id    = 2'(c);
      wb.data  = q.add[2] ? {q.wdata, 32'b0} : {32'b0, q.wdata};
      wb.strb  = q.add[2] ? {q.be, 4'b0} : {4'b0, q.be};
      wb.last  = 1'b1;
      rsp      = '{r_valid: 1'b1, r_rdata: 32'b0, r_opc: redirect};
      wa       = {q.add[31:2], 2'b00};
      for (int i = 0; i < 4; i++) begin
         if (q.wen) begin
            rsp.r_rdata[8*i +: 8] = shadow_byte(wa + i);
         end else if (!redirect && q.be[i]) begin
            shadow[wa + i] = q.wdata[8*i +: 8];
         end
      end
   endfunction

   // Random request in the core's own address window
   task automatic make_request(input int c);
      per_bus_pkg::per_req_t q;
      logic [1:0]  off;
      logic [1:0]  kind;
      logic [6:0]  word;
      logic        half;
      logic [2:0]  op;
      q    = '0;
      off  = rand_bits(2);
      kind = rand_bits(2);
      word = rand_bits(7);
      half = rand_bits(1);
      case (kind)
         2'd0:    q.be = 4'b0001 << off;
         2'd1:    begin
            off[0] = 1'b0;
            q.be   = off[1] ? 4'b1100 : 4'b0011;
         end
         default: q.be = 4'b1111 << off;
      endcase
      q.req   = 1'b1;
      q.add   = {16'h0001, 4'h0, 2'(c), word, half, off};
      q.wdata = rand_bits(32);
      q.wen   = rand_bits(1);
      q.id    = NB'(1) << c;
      if (rand_bits(3) == 0) begin
         op     = rand_bits(3);
         q.wen  = (op == 0);
         case (op)
            3'd0:    q.atop = {1'b1, per_bus_pkg::AMO_LR};
            3'd1:    q.atop = {1'b1, per_bus_pkg::AMO_SC};
            3'd2:    q.atop = {1'b1, per_bus_pkg::AMO_SWAP};
            3'd3:    q.atop = {1'b1, per_bus_pkg::AMO_ADD};
            3'd4:    q.atop = {1'b1, per_bus_pkg::AMO_XOR};
            3'd5:    q.atop = {1'b1, per_bus_pkg::AMO_AND};
            3'd6:    q.atop = {1'b1, per_bus_pkg::AMO_MIN};
            default: q.atop = {1'b1, per_bus_pkg::AMO_MAXU};
         endcase
      end
      per_req[c] <= q;
   endtask

   // ****************************************
   // Compare and drive, once per cycle
   // ****************************************
   always @(posedge clk_i) begin
      axi_bus_pkg::axi_ax_t   ax;
      axi_bus_pkg::axi_w_t    wb;
      per_bus_pkg::per_resp_t rsp;
      logic [NB-1:0]          exp_gnt;
      logic                   found;
      int unsigned            win, idx;
      if (rst_n_i) begin
         // Responses routed one cycle after the handshake
         for (int c = 0; c < NB; c++) begin
            check_resp($sformatf("per_resp_o[%0d]", c), per_resp[c],
                       '{r_valid: due[c], r_rdata: last_rdata, r_opc: last_opc});
            if (due[c]) begin
               state[c] = 0;
               n_done++;
            end
         end
         check_bit("busy_o", busy, outst != 0);
         due = '0;
         if (b_valid) begin
            if (state[b.id] != 2 || exp_read[b.id]) begin
               stop_run("write response for a core with no outstanding write");
            end
            due[b.id] = 1'b1;
            last_opc  = exp_rsp[b.id].r_opc;
            outst--;
         end
         if (r_valid) begin
            if (state[r.id] != 2 || !exp_read[r.id]) begin
               stop_run("read response for a core with no outstanding read");
            end
            due[r.id]  = 1'b1;
            last_opc   = exp_rsp[r.id].r_opc;
            last_rdata = exp_rsp[r.id].r_rdata;
            outst--;
         end
         // Round-robin prediction
         found   = 1'b0;
         win     = 0;
         exp_gnt = '0;
         for (int k = 0; k < NB; k++) begin
            idx = (ptr + k) % NB;
            if (!found && per_req[idx].req) begin
               found = 1'b1;
               win   = idx;
            end
         end
         if (found && aw_ready && ar_ready) begin
            exp_gnt[win] = 1'b1;
         end
         check_gnt("per_gnt_o", per_gnt, exp_gnt);
         if (exp_gnt != '0) begin
            ref_model(per_req[win], win, ax, wb, rsp);
            exp_rsp[win]  = rsp;
            exp_read[win] = per_req[win].wen;
            if (per_req[win].wen) begin
               if (!ar_valid || aw_valid || w_valid) begin
                  stop_run("granted read did not raise ar_valid alone");
               end
               check_ax("ar_o", ar, ax);
            end else begin
               if (!aw_valid || !w_valid || ar_valid) begin
                  stop_run("granted write did not raise aw_valid and w_valid");
               end
               check_ax("aw_o", aw, ax);
               check_w("w_o", w, wb);
            end
            state[win]       = 2;
            per_req[win].req <= 1'b0;
            ptr              = (win + 1) % NB;
            outst++;
         end else if (aw_valid || ar_valid || w_valid) begin
            stop_run("AXI request issued without a grant");
         end
         for (int c = 0; c < NB; c++) begin
            if (state[c] == 0 && n_issued < N_REQ && rand_bits(1)) begin
               make_request(c);
               state[c] = 1;
               n_issued++;
            end
         end
         stall <= (rand_bits(2) == 0);
         lat   <= rand_bits(2);
      end
   end

   initial begin
      per_req = '0;
      stall   = 1'b0;
      lat     = 2'd0;
      rst_n_i = 1'b0;
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      while (n_done < N_REQ) begin
         @(posedge clk_i);
         cycles++;
         if (cycles > CYCLE_LIMIT) begin
            stop_run($sformatf("timeout after %0d cycles with %0d of %0d requests done",
                               cycles, n_done, N_REQ));
         end
      end
      @(posedge clk_i);
      if (busy !== 1'b0 || outst != 0) begin
         stop_run("busy_o still high after the last response");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// ==== verif/axi_mem_model.sv ====
/*
 * AXI4 slave memory for the bridge testbench. Ready is lowered while
 * stall_i is high. Responses are queued and handed back one per cycle,
 * 1 to 3 cycles after acceptance, with SLVERR for the error region.
 */
`timescale 1ns/1ps

module axi_mem_model (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 stall_i,
   input  logic [1:0]           lat_i,
   input  logic                 aw_valid_i,
   input  axi_bus_pkg::axi_ax_t aw_i,
   output logic                 aw_ready_o,
   input  logic                 w_valid_i,
   input  axi_bus_pkg::axi_w_t  w_i,
   output logic                 w_ready_o,
   input  logic                 ar_valid_i,
   input  axi_bus_pkg::axi_ax_t ar_i,
   output logic                 ar_ready_o,
   output logic                 b_valid_o,
   output axi_bus_pkg::axi_b_t  b_o,
   output logic                 r_valid_o,
   output axi_bus_pkg::axi_r_t  r_o
);

   typedef struct packed {
      logic        is_read;
      logic [1:0]  id;
      logic [1:0]  resp;
      logic [63:0] data;
      logic [31:0] due;
   } pend_t;

   logic [63:0] mem [logic [28:0]];
   pend_t       pend [$];
   logic [31:0] cyc;

   // All three readies move together
   assign aw_ready_o = !stall_i;
   assign w_ready_o  = !stall_i;
   assign ar_ready_o = !stall_i;

   // Unwritten words read back as their own address and its inverse
   function automatic logic [63:0] read_word(input logic [28:0] a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return {~{a, 3'b000}, {a, 3'b000}};
   endfunction

   function automatic logic in_err_region(input logic [31:0] addr);
      return addr[31:12] == axi_bus_pkg::ERR_REGION_BASE[31:12];
   endfunction

   always @(posedge clk_i or negedge rst_n_i) begin
      pend_t       p;
      logic [63:0] word;
      if (!rst_n_i) begin
         b_valid_o <= 1'b0;
         r_valid_o <= 1'b0;
         b_o       <= '0;
         r_o       <= '0;
         cyc        = '0;
         pend.delete();
      end else begin
         cyc = cyc + 1;
         if (aw_valid_i && w_valid_i) begin
            p         = '0;
            p.id      = aw_i.id;
            p.due     = cyc + 1 + (lat_i % 3);
            p.resp    = axi_bus_pkg::RESP_OKAY;
            if (in_err_region(aw_i.addr)) begin
               p.resp = axi_bus_pkg::RESP_SLVERR;
            end else begin
               word = read_word(aw_i.addr[31:3]);
               for (int j = 0; j < 8; j++) begin
                  if (w_i.strb[j]) begin
                     word[8*j +: 8] = w_i.data[8*j +: 8];
                  end
               end
               mem[aw_i.addr[31:3]] = word;
            end
            pend.push_back(p);
         end
         if (ar_valid_i) begin
            p         = '0;
            p.is_read = 1'b1;
            p.id      = ar_i.id;
            p.due     = cyc + 1 + (lat_i % 3);
            p.data    = read_word(ar_i.addr[31:3]);
            p.resp    = in_err_region(ar_i.addr) ? axi_bus_pkg::RESP_SLVERR
                                                 : axi_bus_pkg::RESP_OKAY;
            pend.push_back(p);
         end
         // One response per cycle, B and R never together
         b_valid_o <= 1'b0;
         r_valid_o <= 1'b0;
         if (pend.size() > 0 && pend[0].due <= cyc) begin
            p = pend.pop_front();
            if (p.is_read) begin
               r_valid_o <= 1'b1;
               r_o       <= '{data: p.data, resp: p.resp, id: p.id, last: 1'b1};
            end else begin
               b_valid_o <= 1'b1;
               b_o       <= '{resp: p.resp, id: p.id};
            end
         end
      end
   end

endmodule

// ==== logic/per2axi_bridge.sv ====
/*
 * Peripheral to AXI4 bridge top. Arbiter, request channel, response
 * channel and busy counter wired together, nothing else.
 */
`timescale 1ns/1ps

module per2axi_bridge (
   input  logic                                                 clk_i,
   input  logic                                                 rst_n_i,

   // Core side
   input  per_bus_pkg::per_req_t  [per_bus_pkg::NB_CORES-1:0]   per_req_i,
   output logic                   [per_bus_pkg::NB_CORES-1:0]   per_gnt_o,
   output per_bus_pkg::per_resp_t [per_bus_pkg::NB_CORES-1:0]   per_resp_o,

   // ****************************************
   // AXI4 master
   // ****************************************
   output logic                                                 aw_valid_o,
   output axi_bus_pkg::axi_ax_t                                 aw_o,
   input  logic                                                 aw_ready_i,
   output logic                                                 w_valid_o,
   output axi_bus_pkg::axi_w_t                                  w_o,
   input  logic                                                 w_ready_i,
   output logic                                                 ar_valid_o,
   output axi_bus_pkg::axi_ax_t                                 ar_o,
   input  logic                                                 ar_ready_i,
   input  logic                                                 b_valid_i,
   input  axi_bus_pkg::axi_b_t                                  b_i,
   input  logic                                                 r_valid_i,
   input  axi_bus_pkg::axi_r_t                                  r_i,

   output logic                                                 busy_o
);

   per_bus_pkg::per_req_t                  arb_req;
   logic                                   arb_gnt;
   logic                                   trans_req;
   logic [axi_bus_pkg::AXI_ID_WIDTH-1:0]   trans_id;
   logic [axi_bus_pkg::AXI_ADDR_WIDTH-1:0] trans_add;

   per_arbiter u_arbiter (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_req_i (per_req_i),
      .core_gnt_o (per_gnt_o),
      .bus_req_o  (arb_req),
      .bus_gnt_i  (arb_gnt)
   );

   per2axi_req_channel u_req_channel (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (arb_req),
      .gnt_o       (arb_gnt),
      .aw_valid_o  (aw_valid_o),
      .aw_o        (aw_o),
      .aw_ready_i  (aw_ready_i),
      .w_valid_o   (w_valid_o),
      .w_o         (w_o),
      .w_ready_i   (w_ready_i),
      .ar_valid_o  (ar_valid_o),
      .ar_o        (ar_o),
      .ar_ready_i  (ar_ready_i),
      .trans_req_o (trans_req),
      .trans_id_o  (trans_id),
      .trans_add_o (trans_add)
   );

   per2axi_res_channel u_res_channel (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .b_valid_i   (b_valid_i),
      .b_i         (b_i),
      .r_valid_i   (r_valid_i),
      .r_i         (r_i),
      .trans_req_i (trans_req),
      .trans_id_i  (trans_id),
      .trans_add_i (trans_add),
      .core_resp_o (per_resp_o)
   );

   // AW/AR valids only rise with ready and B/R are always taken,
   // so each valid is already a handshake
   per2axi_busy_unit u_busy_unit (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .aw_hs_i (aw_valid_o),
      .ar_hs_i (ar_valid_o),
      .b_hs_i  (b_valid_i),
      .r_hs_i  (r_valid_i),
      .busy_o  (busy_o)
   );

endmodule

// ==== logic/per2axi_busy_unit.sv ====
/*
 * Outstanding transaction counter. busy_o follows the registered
 * count, so it moves one cycle after the handshake.
 */
`timescale 1ns/1ps

module per2axi_busy_unit (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic aw_hs_i,
   input  logic ar_hs_i,
   input  logic b_hs_i,
   input  logic r_hs_i,
   output logic busy_o
);

   logic [per_bus_pkg::OUTST_CNT_WIDTH-1:0] cnt_q, cnt_d;

   // Up on address accept, down on response
   assign cnt_d = cnt_q
                + per_bus_pkg::OUTST_CNT_WIDTH'(aw_hs_i)
                + per_bus_pkg::OUTST_CNT_WIDTH'(ar_hs_i)
                - per_bus_pkg::OUTST_CNT_WIDTH'(b_hs_i)
                - per_bus_pkg::OUTST_CNT_WIDTH'(r_hs_i);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_d;
      end
   end

   assign busy_o = (cnt_q != '0);

   a_no_orphan_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (b_hs_i || r_hs_i) |-> (cnt_q != '0))
      else $error("response with no transaction outstanding");

endmodule

// ==== logic/per2axi_res_channel.sv ====
/*
 * Response side of the bridge. Routes AXI B and R beats back to the
 * issuing core one cycle later, picking the read half per ID.
 */
`timescale 1ns/1ps

module per2axi_res_channel (
   input  logic                                                 clk_i,
   input  logic                                                 rst_n_i,

   input  logic                                                 b_valid_i,
   input  axi_bus_pkg::axi_b_t                                  b_i,
   input  logic                                                 r_valid_i,
   input  axi_bus_pkg::axi_r_t                                  r_i,

   input  logic                                                 trans_req_i,
   input  logic [axi_bus_pkg::AXI_ID_WIDTH-1:0]                 trans_id_i,
   input  logic [axi_bus_pkg::AXI_ADDR_WIDTH-1:0]               trans_add_i,

   output per_bus_pkg::per_resp_t [per_bus_pkg::NB_CORES-1:0]   core_resp_o
);

   // add[2] of the outstanding read, one entry per ID
   logic [2**axi_bus_pkg::AXI_ID_WIDTH-1:0] upper_half_q;

   logic [per_bus_pkg::NB_CORES-1:0] valid_d, valid_q;
   logic [31:0]                      rdata_q;
   logic                             opc_q;
   logic [1:0]                       resp;

   always_ff @(posedge clk_i) begin
      if (trans_req_i) begin
         upper_half_q[trans_id_i] <= trans_add_i[2];
      end
   end

   // ****************************************
   // Response routing
   // ****************************************
   always_comb begin
      valid_d = '0;
      resp    = r_i.resp;
      if (b_valid_i) begin
         valid_d[b_i.id] = 1'b1;
         resp            = b_i.resp;
      end else if (r_valid_i) begin
         valid_d[r_i.id] = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else begin
         valid_q <= valid_d;
      end
   end

   // Payload shared by all cores, only the valid is routed
   always_ff @(posedge clk_i) begin
      if (b_valid_i || r_valid_i) begin
         opc_q <= (resp == axi_bus_pkg::RESP_SLVERR);
      end
      if (r_valid_i && !b_valid_i) begin
         rdata_q <= upper_half_q[r_i.id] ? r_i.data[63:32] : r_i.data[31:0];
      end
   end

   always_comb begin
      for (int c = 0; c < per_bus_pkg::NB_CORES; c++) begin
         core_resp_o[c].r_valid = valid_q[c];
         core_resp_o[c].r_rdata = rdata_q;
         core_resp_o[c].r_opc   = opc_q;
      end
   end

   // Memory model hands back one response at a time
   a_b_r_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(b_valid_i && r_valid_i))
      else $error("B and R responses in the same cycle");

endmodule

// ==== logic/per2axi_req_channel.sv ====
/*
 * Request side of the bridge. Maps one granted peripheral request
 * onto single-beat AXI AW/W or AR, purely combinational.
 */
`timescale 1ns/1ps

module per2axi_req_channel (
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,

   input  per_bus_pkg::per_req_t                    req_i,
   output logic                                     gnt_o,

   output logic                                     aw_valid_o,
   output axi_bus_pkg::axi_ax_t                     aw_o,
   input  logic                                     aw_ready_i,

   output logic                                     w_valid_o,
   output axi_bus_pkg::axi_w_t                      w_o,
   input  logic                                     w_ready_i,

   output logic                                     ar_valid_o,
   output axi_bus_pkg::axi_ax_t                     ar_o,
   input  logic                                     ar_ready_i,

   output logic                                     trans_req_o,
   output logic [axi_bus_pkg::AXI_ID_WIDTH-1:0]     trans_id_o,
   output logic [axi_bus_pkg::AXI_ADDR_WIDTH-1:0]   trans_add_o
);

   logic [axi_bus_pkg::AXI_ID_WIDTH-1:0] id_bin;
   logic [2:0]                           size;

   // ****************************************
   // Valid generation
   // ****************************************
   // Valids only rise when the slave is ready, so they never wait
   always_comb begin
      aw_valid_o = 1'b0;
      w_valid_o  = 1'b0;
      ar_valid_o = 1'b0;
      if (req_i.req && !req_i.wen && aw_ready_i && w_ready_i) begin
         aw_valid_o = 1'b1;
         w_valid_o  = 1'b1;
      end else if (req_i.req && req_i.wen && ar_ready_i) begin
         ar_valid_o = 1'b1;
      end
   end

   assign gnt_o = aw_ready_i && ar_ready_i;

   // One-hot to binary
   always_comb begin
      id_bin = '0;
      for (int i = 0; i < per_bus_pkg::PER_ID_WIDTH; i++) begin
         if (req_i.id[i]) begin
            id_bin = axi_bus_pkg::AXI_ID_WIDTH'(i);
         end
      end
   end

   // Size from byte enables
   always_comb begin
      if (req_i.be == (4'b0001 << req_i.add[1:0])) begin
         size = 3'd0;
      end else if ((req_i.add[1:0] == 2'b00 && req_i.be == 4'b0011) ||
                   (req_i.add[1:0] == 2'b10 && req_i.be == 4'b1100)) begin
         size = 3'd1;
      end else begin
         size = 3'd2;
      end
   end

   // ****************************************
   // Address channels and atomics
   // ****************************************
   always_comb begin
      aw_o.addr  = req_i.add;
      aw_o.size  = size;
      aw_o.len   = 8'd0;
      aw_o.burst = axi_bus_pkg::BURST_INCR;
      aw_o.lock  = 1'b0;
      aw_o.id    = id_bin;
      ar_o       = aw_o;
      if (req_i.atop[5]) begin
         case (req_i.atop[4:0])
            per_bus_pkg::AMO_LR: ar_o.lock = 1'b1;
            per_bus_pkg::AMO_SC: aw_o.lock = 1'b1;
            per_bus_pkg::AMO_SWAP, per_bus_pkg::AMO_ADD, per_bus_pkg::AMO_XOR,
            per_bus_pkg::AMO_AND, per_bus_pkg::AMO_OR, per_bus_pkg::AMO_MIN,
            per_bus_pkg::AMO_MAX, per_bus_pkg::AMO_MINU, per_bus_pkg::AMO_MAXU: begin
               // No atomic unit downstream so the error slave takes them
               aw_o.addr = axi_bus_pkg::ERR_REGION_BASE + {20'b0, req_i.add[11:0]};
            end
            default: ;
         endcase
      end
   end

   // Lane placement on the 64-bit bus
   always_comb begin
      w_o.last = w_valid_o;
      if (!req_i.add[2]) begin
         w_o.data = {32'b0, req_i.wdata};
         w_o.strb = {4'b0, req_i.be};
      end else begin
         w_o.data = {req_i.wdata, 32'b0};
         w_o.strb = {req_i.be, 4'b0};
      end
   end

   // Read half is remembered by the response channel
   assign trans_req_o = ar_valid_o;
   assign trans_id_o  = ar_o.id;
   assign trans_add_o = ar_o.addr;

   a_be_addressed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i.req |-> req_i.be[req_i.add[1:0]])
      else $error("addressed byte not enabled");

   a_be_no_lower: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i.req |-> ((req_i.be & ((4'b0001 << req_i.add[1:0]) - 4'b0001)) == 4'b0000))
      else $error("byte enabled below addressed byte");

endmodule

// ==== logic/per_arbiter.sv ====
/*
 * Round-robin arbiter folding the core request ports onto one
 * peripheral port. Combinational select, pointer advances on grant.
 */
`timescale 1ns/1ps

module per_arbiter (
   input  logic                                                clk_i,
   input  logic                                                rst_n_i,
   input  per_bus_pkg::per_req_t [per_bus_pkg::NB_CORES-1:0]   core_req_i,
   output logic [per_bus_pkg::NB_CORES-1:0]                    core_gnt_o,
   output per_bus_pkg::per_req_t                               bus_req_o,
   input  logic                                                bus_gnt_i
);

   logic [per_bus_pkg::CORE_IDX_WIDTH-1:0] ptr_q;
   logic [per_bus_pkg::CORE_IDX_WIDTH-1:0] win_idx;
   logic                                   found;
   logic [per_bus_pkg::NB_CORES-1:0]       req_vec;

   always_comb begin
      for (int k = 0; k < per_bus_pkg::NB_CORES; k++) begin
         req_vec[k] = core_req_i[k].req;
      end
   end

   // First requester at or after the pointer
   always_comb begin
      int unsigned idx;
      found   = 1'b0;
      win_idx = ptr_q;
      for (int k = 0; k < per_bus_pkg::NB_CORES; k++) begin
         idx = (int'(ptr_q) + k) % per_bus_pkg::NB_CORES;
         if (!found && core_req_i[idx].req) begin
            found   = 1'b1;
            win_idx = idx[per_bus_pkg::CORE_IDX_WIDTH-1:0];
         end
      end
   end

   // Forward the winner with its ID rewritten to its own index
   always_comb begin
      bus_req_o     = core_req_i[win_idx];
      bus_req_o.req = found;
      bus_req_o.id  = '0;
      if (found) begin
         bus_req_o.id[win_idx] = 1'b1;
      end
   end

   always_comb begin
      core_gnt_o = '0;
      if (found && bus_gnt_i) begin
         core_gnt_o[win_idx] = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ptr_q <= '0;
      end else if (found && bus_gnt_i) begin
         if (win_idx == per_bus_pkg::CORE_IDX_WIDTH'(per_bus_pkg::NB_CORES - 1)) begin
            ptr_q <= '0;
         end else begin
            ptr_q <= win_idx + 1'b1;
         end
      end
   end

   a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(core_gnt_o))
      else $error("core grant not one-hot");

   // A waiting core keeps its request up until it is granted
   a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (($past(req_vec & ~core_gnt_o) & ~req_vec) == '0))
      else $error("core dropped its request before the grant");

endmodule

// ==== logic/axi_bus_pkg.sv ====
/*
 * AXI4 channel types and codes for the bridge master port.
 * Only the fields a single-beat master needs are carried.
 */
package axi_bus_pkg;

   localparam int unsigned AXI_ADDR_WIDTH = 32;
   localparam int unsigned AXI_DATA_WIDTH = 64;
   localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
   localparam int unsigned AXI_ID_WIDTH   = 2;

   // Burst and response encodings
   localparam logic [1:0] BURST_INCR  = 2'b01;
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Atomics other than LR/SC land here and get SLVERR
   localparam logic [AXI_ADDR_WIDTH-1:0] ERR_REGION_BASE = 32'h1B00_0000;

   // ****************************************
   // Channel payloads
   // ****************************************
   // Shared by AW and AR
   typedef struct packed {
      logic [AXI_ADDR_WIDTH-1:0] addr;
      logic [2:0]                size;
      logic [7:0]                len;
      logic [1:0]                burst;
      logic                      lock;
      logic [AXI_ID_WIDTH-1:0]   id;
   } axi_ax_t;

   typedef struct packed {
      logic [AXI_DATA_WIDTH-1:0] data;
      logic [AXI_STRB_WIDTH-1:0] strb;
      logic                      last;
   } axi_w_t;

   typedef struct packed {
      logic [1:0]              resp;
      logic [AXI_ID_WIDTH-1:0] id;
   } axi_b_t;

   typedef struct packed {
      logic [AXI_DATA_WIDTH-1:0] data;
      logic [1:0]                resp;
      logic [AXI_ID_WIDTH-1:0]   id;
      logic                      last;
   } axi_r_t;

endpackage

// ==== logic/per_bus_pkg.sv ====
/*
 * Peripheral interconnect types shared by the cores and the bridge.
 * Holds the request and response structs, core count and AMO opcodes.
 */
package per_bus_pkg;

   localparam int unsigned NB_CORES          = 4;
   localparam int unsigned PER_ID_WIDTH      = NB_CORES;
   localparam int unsigned CORE_IDX_WIDTH    = $clog2(NB_CORES);
   // Counter must reach NB_CORES itself
   localparam int unsigned OUTST_CNT_WIDTH   = $clog2(NB_CORES + 1);

   // ****************************************
   // Request and response
   // ****************************************
   typedef struct packed {
      logic                    req;
      logic [31:0]             add;
      logic                    wen;    // low for write
      logic [5:0]              atop;   // bit 5 flags an atomic
      logic [31:0]             wdata;
      logic [3:0]              be;
      logic [PER_ID_WIDTH-1:0] id;     // one-hot requester
   } per_req_t;

   typedef struct packed {
      logic        r_valid;
      logic [31:0] r_rdata;
      logic        r_opc;              // error flag
   } per_resp_t;

   // ****************************************
   // Atomic opcodes, atop[4:0]
   // ****************************************
   localparam logic [4:0] AMO_LR   = 5'b00010;
   localparam logic [4:0] AMO_SC   = 5'b00011;
   localparam logic [4:0] AMO_SWAP = 5'b00001;
   localparam logic [4:0] AMO_ADD  = 5'b00000;
   localparam logic [4:0] AMO_XOR  = 5'b00100;
   localparam logic [4:0] AMO_AND  = 5'b01100;
   localparam logic [4:0] AMO_OR   = 5'b01000;
   localparam logic [4:0] AMO_MIN  = 5'b10000;
   localparam logic [4:0] AMO_MAX  = 5'b10100;
   localparam logic [4:0] AMO_MINU = 5'b11000;
   localparam logic [4:0] AMO_MAXU = 5'b11100;

endpackage
